//--- list.f
hdl/eth_rx_pkg.sv
hdl/mii_nibble_assembler.sv
hdl/eth_crc32.sv
hdl/rx_frame_ctrl.sv
hdl/rx_frame_buffer.sv
hdl/eth_rx_regs.sv
hdl/eth_rx_top.sv
test/tb_eth_rx.sv

//--- Makefile
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f list.f --top-module tb_eth_rx

sim:
	verilator --binary --timing -f list.f --top-module tb_eth_rx -o tb_eth_rx
	./obj_dir/tb_eth_rx | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- test/tb_eth_rx.sv
`timescale 1ns/1ps

module tb_eth_rx;

   typedef logic [7:0] byte_q_t[$];

   localparam int ifg_cycles = 24;
   localparam int poll_limit = 16;
   localparam int axi_cycles = 8;
   // Preamble, up to 68 frame bytes and the gap, two nibbles per byte
   localparam int frame_cycles = 2 * (8 + 68) + ifg_cycles + 4;
   localparam int timeout_cycles = 2 * (9 * frame_cycles + 160 * axi_cycles
                                        + 6 * poll_limit * axi_cycles);

   logic        RX_CLK;
   logic        rst;
   logic [3:0]  RX_DATA;
   logic        RX_DV;
   logic [11:0] awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wvalid;
   logic        wready;
   logic [1:0]  bresp;
   logic        bvalid;
   logic        bready;
   logic [11:0] araddr;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rvalid;
   logic        rready;

   string test_name;
   int    errors;
   int    errors_at_start;
   int    tests_run;
   int    tests_bad;
   int    exp_drops;

   eth_rx_top eth_rx_top_inst (
      .RX_CLK  (RX_CLK),
      .rst     (rst),
      .RX_DATA (RX_DATA),
      .RX_DV   (RX_DV),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rvalid  (rvalid),
      .rready  (rready)
   );

   initial begin
      RX_CLK = 1'b0;
      forever #50 RX_CLK = ~RX_CLK;
   end

   initial begin
      int cycles;
      cycles = 0;
      while (cycles < timeout_cycles) begin
         @(posedge RX_CLK);
         cycles++;
      end
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Regression failed");
      $finish;
   end

   task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
      $display("Mismatch in %s: %s expected 0x%08h actual 0x%08h", test_name, what, exp, act);
      errors++;
   endtask

   task automatic report_failure(input string msg);
      $display("Error in %s: %s", test_name, msg);
      errors++;
   endtask

   task automatic start_test(input string name);
      test_name = name;
      errors_at_start = errors;
      tests_run++;
   endtask

   task automatic end_test();
      if (errors == errors_at_start) begin
         $display("%s: ok", test_name);
      end else begin
         tests_bad++;
         $display("%s: %0d errors", test_name, errors - errors_at_start);
      end
   endtask

   task automatic axi_write(input logic [11:0] addr, input logic [31:0] data);
      @(posedge RX_CLK);
      #1;
      awaddr = addr;
      wdata = data;
      wstrb = 4'hF;
      awvalid = 1'b1;
      wvalid = 1'b1;
      bready = 1'b1;
      do begin
         @(negedge RX_CLK);
      end while (!awready);
      if (wready !== 1'b1) report_failure("wready was low in the cycle that awready was high");
      @(posedge RX_CLK);
      #1;
      awvalid = 1'b0;
      wvalid = 1'b0;
      do begin
         @(negedge RX_CLK);
      end while (!bvalid);
      if (bresp !== 2'b00) mismatch("write response", 32'd0, 32'(bresp));
      @(posedge RX_CLK);
      #1;
      bready = 1'b0;
   endtask

   task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
      @(posedge RX_CLK);
      #1;
      araddr = addr;
      arvalid = 1'b1;
      rready = 1'b1;
      do begin
         @(negedge RX_CLK);
      end while (!arready);
      @(posedge RX_CLK);
      #1;
      arvalid = 1'b0;
      do begin
         @(negedge RX_CLK);
      end while (!rvalid);
      data = rdata;
      if (rresp !== 2'b00) mismatch("read response", 32'd0, 32'(rresp));
      @(posedge RX_CLK);
      #1;
      rready = 1'b0;
   endtask

   task automatic expect_reg(input string what, input logic [11:0] addr, input logic [31:0] exp);
      logic [31:0] got;
      axi_read(addr, got);
      if (got !== exp) mismatch(what, exp, got);
   endtask

   task automatic drive_nibble(input logic dv, input logic [3:0] data);
      @(posedge RX_CLK);
      #1;
      RX_DV = dv;
      RX_DATA = data;
   endtask

   // Preamble and SFD, then the frame low nibble first, then the interframe gap
   task automatic send_frame(input byte_q_t frame);
      for (int i = 0; i < 8; i++) begin
         drive_nibble(1'b1, 4'h5);
         drive_nibble(1'b1, (i == 7) ? 4'hD : 4'h5);
      end
      foreach (frame[i]) begin
         drive_nibble(1'b1, frame[i][3:0]);
         drive_nibble(1'b1, frame[i][7:4]);
      end
      repeat (ifg_cycles) drive_nibble(1'b0, 4'h0);
   endtask

   // Ethernet FCS, reflected CRC-32 with final inversion
   function automatic logic [31:0] fcs_of(input byte_q_t bytes);
      logic [31:0] c;
      c = 32'hFFFF_FFFF;
      foreach (bytes[i]) begin
         c = c ^ {24'd0, bytes[i]};
         repeat (8) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
         end
      end
      return ~c;
   endfunction

   // Destination, random payload, FCS least significant byte first
   function automatic byte_q_t build_frame(input logic [47:0] dest, input int n_payload);
      byte_q_t     f;
      logic [31:0] fcs;
      for (int i = 5; i >= 0; i--) begin
         f.push_back(dest[8 * i +: 8]);
      end
      for (int i = 0; i < n_payload; i++) begin
         f.push_back(8'($urandom));
      end
      fcs = fcs_of(f);
      for (int i = 0; i < 4; i++) begin
         f.push_back(fcs[8 * i +: 8]);
      end
      return f;
   endfunction

   function automatic logic [31:0] status_word(input logic ready, input logic err,
                                               input logic [9:0] size);
      return {6'd0, size, 14'd0, err, ready};
   endfunction

   task automatic wait_ready(output logic [31:0] st);
      int polls;
      polls = 0;
      st = '0;
      while (!st[0] && polls < poll_limit) begin
         axi_read(eth_rx_pkg::reg_status, st);
         polls++;
      end
      if (!st[0]) begin
         report_failure($sformatf("frame_ready did not rise within %0d status reads",
                                  poll_limit));
      end
   endtask

   // Little-endian packing, unused upper lanes of the last word are zero
   task automatic check_buffer(input byte_q_t frame);
      logic [31:0] exp;
      logic [31:0] got;
      int          n_words;
      n_words = (frame.size() + 3) / 4;
      for (int w = 0; w < n_words; w++) begin
         exp = '0;
         for (int l = 0; l < 4; l++) begin
            if (4 * w + l < frame.size()) exp[8 * l +: 8] = frame[4 * w + l];
         end
         axi_read(eth_rx_pkg::buf_base + 12'(4 * w), got);
         if (got !== exp) mismatch($sformatf("buffer word %0d", w), exp, got);
      end
   endtask

   task automatic expect_frame(input byte_q_t frame, input logic err);
      logic [31:0] st;
      logic [31:0] exp;
      exp = status_word(1'b1, err, 10'(frame.size()));
      wait_ready(st);
      if (st !== exp) mismatch("status", exp, st);
      check_buffer(frame);
   endtask

   task automatic reset_values();
      start_test("reset_values");
      expect_reg("status", eth_rx_pkg::reg_status, 32'd0);
      expect_reg("drops", eth_rx_pkg::reg_drops, 32'd0);
      expect_reg("phy status", eth_rx_pkg::reg_phy, 32'd0);
      end_test();
   endtask

   task automatic unicast_frame();
      byte_q_t f;
      start_test("unicast_frame");
      f = build_frame(eth_rx_pkg::mac_addr, 58);
      send_frame(f);
      expect_frame(f, 1'b0);
      expect_reg("phy status", eth_rx_pkg::reg_phy, 32'd1);
      end_test();
   endtask

   task automatic broadcast_and_bad_crc();
      byte_q_t f;
      start_test("broadcast_and_bad_crc");
      axi_write(eth_rx_pkg::reg_control, 32'd1);
      f = build_frame('1, 58);
      send_frame(f);
      expect_frame(f, 1'b0);
      axi_write(eth_rx_pkg::reg_control, 32'd1);
      f = build_frame(eth_rx_pkg::mac_addr, 58);
      // One payload bit flipped after the FCS was computed
      f[20] = f[20] ^ 8'h10;
      send_frame(f);
      expect_frame(f, 1'b1);
      end_test();
   endtask

   task automatic drop_counting();
      byte_q_t     held;
      byte_q_t     f;
      logic [31:0] st;
      start_test("drop_counting");
      axi_write(eth_rx_pkg::reg_control, 32'd1);
      f = build_frame(48'h02_00_00_00_00_3A, 58);
      send_frame(f);
      exp_drops++;
      axi_read(eth_rx_pkg::reg_status, st);
      if (st[0] !== 1'b0) mismatch("frame_ready after address miss", 32'd0, 32'(st[0]));
      expect_reg("drops", eth_rx_pkg::reg_drops, 32'(exp_drops));
      held = build_frame(eth_rx_pkg::mac_addr, 58);
      send_frame(held);
      expect_frame(held, 1'b0);
      f = build_frame(eth_rx_pkg::mac_addr, 58);
      send_frame(f);
      exp_drops++;
      expect_reg("drops", eth_rx_pkg::reg_drops, 32'(exp_drops));
      expect_reg("held status", eth_rx_pkg::reg_status, status_word(1'b1, 1'b0, 10'd68));
      check_buffer(held);
      end_test();
   endtask

   task automatic ack_and_partial_word();
      byte_q_t     f;
      logic [31:0] st;
      start_test("ack_and_partial_word");
      axi_write(eth_rx_pkg::reg_control, 32'd1);
      axi_read(eth_rx_pkg::reg_status, st);
      if (st[0] !== 1'b0) mismatch("frame_ready after ack", 32'd0, 32'(st[0]));
      f = build_frame(eth_rx_pkg::mac_addr, 58);
      send_frame(f);
      expect_frame(f, 1'b0);
      axi_write(eth_rx_pkg::reg_control, 32'd1);
      // 55 bytes, the last word holds three lanes
      f = build_frame(eth_rx_pkg::mac_addr, 45);
      send_frame(f);
      expect_frame(f, 1'b0);
      end_test();
   endtask

   task automatic soft_reset_held();
      byte_q_t     f;
      logic [31:0] st;
      start_test("soft_reset_held");
      axi_write(eth_rx_pkg::reg_control, 32'd2);
      axi_read(eth_rx_pkg::reg_status, st);
      if (st[0] !== 1'b0) mismatch("frame_ready after soft reset", 32'd0, 32'(st[0]));
      expect_reg("drops", eth_rx_pkg::reg_drops, 32'(exp_drops));
      // Receiver recovers from the soft reset
      f = build_frame(eth_rx_pkg::mac_addr, 58);
      send_frame(f);
      expect_frame(f, 1'b0);
      end_test();
   endtask

   initial begin
      rst = 1'b1;
      RX_DATA = 4'h0;
      RX_DV = 1'b0;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = '0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      errors = 0;
      tests_run = 0;
      tests_bad = 0;
      exp_drops = 0;
      void'($urandom(39));
      repeat (5) @(posedge RX_CLK);
      #1;
      rst = 1'b0;

      reset_values();
      unicast_frame();
      broadcast_and_bad_crc();
      drop_counting();
      ack_and_partial_word();
      soft_reset_held();

      $display("Summary: %0d tests, %0d with errors, %0d errors in total",
               tests_run, tests_bad, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

//--- hdl/eth_rx_top.sv
`timescale 1ns/1ps

module eth_rx_top (
   input  logic        RX_CLK,
   input  logic        rst,
   input  logic [3:0]  RX_DATA,
   input  logic        RX_DV,
   input  logic [11:0] awaddr,
   input  logic        awvalid,
   output logic        awready,
   input  logic [31:0] wdata,
   input  logic [3:0]  wstrb,
   input  logic        wvalid,
   output logic        wready,
   output logic [1:0]  bresp,
   output logic        bvalid,
   input  logic        bready,
   input  logic [11:0] araddr,
   input  logic        arvalid,
   output logic        arready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        rvalid,
   input  logic        rready
);

   eth_rx_pkg::mii_rx_t    mii;
   eth_rx_pkg::rx_byte_t   rx_byte;
   eth_rx_pkg::buf_wr_t    buf_wr;
   eth_rx_pkg::rx_status_t status;
   eth_rx_pkg::rx_cmd_t    cmd;
   logic [31:0]            drops;
   logic [31:0]            buf_rd_data;
   logic [6:0]             buf_rd_addr;
   logic                   crc_good;
   logic                   crc_clear;
   logic                   soft_rst_q;
   logic                   rst_int;

   assign mii = '{dv: RX_DV, data: RX_DATA};

   // Soft reset pulse, registered before it reaches the datapath
   always_ff @(posedge RX_CLK or posedge rst) begin
      if (rst) begin
         soft_rst_q <= 1'b0;
      end else begin
         soft_rst_q <= cmd.soft_rst;
      end
   end

   assign rst_int = rst | soft_rst_q;

   mii_nibble_assembler mii_nibble_assembler_inst (
      .RX_CLK  (RX_CLK),
      .rst     (rst_int),
      .mii     (mii),
      .rx_byte (rx_byte)
   );

   eth_crc32 eth_crc32_inst (
      .RX_CLK   (RX_CLK),
      .rst      (rst_int),
      .clear    (crc_clear),
      .rx_byte  (rx_byte),
      .crc_good (crc_good)
   );

   // Controller sees cmd.soft_rst directly and keeps its drop counter
   rx_frame_ctrl rx_frame_ctrl_inst (
      .RX_CLK    (RX_CLK),
      .rst       (rst),
      .rx_byte   (rx_byte),
      .crc_good  (crc_good),
      .cmd       (cmd),
      .crc_clear (crc_clear),
      .buf_wr    (buf_wr),
      .status    (status),
      .drops     (drops)
   );

   rx_frame_buffer rx_frame_buffer_inst (
      .RX_CLK    (RX_CLK),
      .rst       (rst_int),
      .buf_wr    (buf_wr),
      .frame_end (status.frame_ready),
      .rd_addr   (buf_rd_addr),
      .rd_data   (buf_rd_data)
   );

   eth_rx_regs eth_rx_regs_inst (
      .RX_CLK      (RX_CLK),
      .rst         (rst),
      .awaddr      (awaddr),
      .awvalid     (awvalid),
      .awready     (awready),
      .wdata       (wdata),
      .wstrb       (wstrb),
      .wvalid      (wvalid),
      .wready      (wready),
      .bresp       (bresp),
      .bvalid      (bvalid),
      .bready      (bready),
      .araddr      (araddr),
      .arvalid     (arvalid),
      .arready     (arready),
      .rdata       (rdata),
      .rresp       (rresp),
      .rvalid      (rvalid),
      .rready      (rready),
      .status      (status),
      .drops       (drops),
      .buf_rd_addr (buf_rd_addr),
      .buf_rd_data (buf_rd_data),
      .cmd         (cmd)
   );

endmodule

//--- hdl/eth_rx_regs.sv
`timescale 1ns/1ps

module eth_rx_regs (
   input  logic                   RX_CLK,
   input  logic                   rst,
   input  logic [11:0]            awaddr,
   input  logic                   awvalid,
   output logic                   awready,
   input  logic [31:0]            wdata,
   input  logic [3:0]             wstrb,
   input  logic                   wvalid,
   output logic                   wready,
   output logic [1:0]             bresp,
   output logic                   bvalid,
   input  logic                   bready,
   input  logic [11:0]            araddr,
   input  logic                   arvalid,
   output logic                   arready,
   output logic [31:0]            rdata,
   output logic [1:0]             rresp,
   output logic                   rvalid,
   input  logic                   rready,
   input  eth_rx_pkg::rx_status_t status,
   input  logic [31:0]            drops,
   output logic [6:0]             buf_rd_addr,
   input  logic [31:0]            buf_rd_data,
   output eth_rx_pkg::rx_cmd_t    cmd
);

   logic        wr_fire;
   logic        rd_pend;
   logic [11:0] ar_off;
   logic [11:0] rd_addr_q;
   logic [11:0] rd_off_q;
   logic        in_buf;
   logic [31:0] rd_word;

   // AW and W are taken together
   assign wr_fire = awvalid && wvalid && !bvalid;
   assign awready = wr_fire;
   assign wready = wr_fire;
   assign bresp = 2'b00;

   always_ff @(posedge RX_CLK or posedge rst) begin
      if (rst) begin
         bvalid <= 1'b0;
         cmd <= '0;
      end else begin
         cmd <= '0;
         if (wr_fire) begin
            bvalid <= 1'b1;
            if (awaddr == eth_rx_pkg::reg_control && wstrb[0]) begin
               cmd.ack <= wdata[0];
               cmd.soft_rst <= wdata[1];
            end
         end else if (bready) begin
            bvalid <= 1'b0;
         end
      end
   end

   // One read in flight, RAM address goes out with the AR handshake
   assign arready = arvalid && !rd_pend && !rvalid;
   assign ar_off = araddr - eth_rx_pkg::buf_base;
   assign buf_rd_addr = ar_off[8:2];
   assign rresp = 2'b00;

   assign rd_off_q = rd_addr_q - eth_rx_pkg::buf_base;
   assign in_buf = (rd_addr_q >= eth_rx_pkg::buf_base) &&
                   (32'(rd_off_q) < eth_rx_pkg::buf_words * 4);

   always_comb begin
      rd_word = '0;
      case (rd_addr_q)
         eth_rx_pkg::reg_status: begin
            rd_word[0] = status.frame_ready;
            rd_word[1] = status.crc_err;
            rd_word[16 +: eth_rx_pkg::size_w] = status.size;
         end
         eth_rx_pkg::reg_drops: rd_word = drops;
         eth_rx_pkg::reg_phy: rd_word[0] = status.dv_seen;
         default: begin
            if (in_buf) begin
               rd_word = buf_rd_data;
            end
         end
      endcase
   end

   always_ff @(posedge RX_CLK or posedge rst) begin
      if (rst) begin
         rd_pend <= 1'b0;
         rvalid <= 1'b0;
      end else begin
         rd_pend <= arready;
         if (rd_pend) begin
            rvalid <= 1'b1;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge RX_CLK) begin
      if (arready) begin
         rd_addr_q <= araddr;
      end
      if (rd_pend) begin
         rdata <= rd_word;
      end
   end

endmodule

//--- hdl/rx_frame_buffer.sv
`timescale 1ns/1ps

module rx_frame_buffer (
   input  logic                RX_CLK,
   input  logic                rst,
   input  eth_rx_pkg::buf_wr_t buf_wr,
   input  logic                frame_end,
   input  logic [6:0]          rd_addr,
   output logic [31:0]         rd_data
);

   logic [31:0] mem [eth_rx_pkg::buf_words];
   logic [31:0] word;
   logic [6:0]  word_addr;
   logic        full_q;
   logic        partial;
   logic        mem_we;

   // Full word after lane 3, or the tail of the frame
   assign mem_we = full_q || (frame_end && partial);

   always_ff @(posedge RX_CLK or posedge rst) begin
      if (rst) begin
         full_q <= 1'b0;
         partial <= 1'b0;
      end else begin
         full_q <= buf_wr.en && (buf_wr.addr[1:0] == 2'd3);
         if (buf_wr.en) begin
            partial <= 1'b1;
         end else if (mem_we) begin
            partial <= 1'b0;
         end
      end
   end

   always_ff @(posedge RX_CLK) begin
      if (buf_wr.en) begin
         word_addr <= buf_wr.addr[8:2];
         // Lane 0 starts a fresh word, so unused upper lanes read as zero
         if (buf_wr.addr[1:0] == 2'd0) begin
            word <= {24'd0, buf_wr.data};
         end else begin
            word[8 * buf_wr.addr[1:0] +: 8] <= buf_wr.data;
         end
      end
      if (mem_we) begin
         mem[word_addr] <= word;
      end
      rd_data <= mem[rd_addr];
   end

endmodule

//--- hdl/rx_frame_ctrl.sv
`timescale 1ns/1ps

module rx_frame_ctrl (
   input  logic                   RX_CLK,
   input  logic                   rst,
   input  eth_rx_pkg::rx_byte_t   rx_byte,
   input  logic                   crc_good,
   input  eth_rx_pkg::rx_cmd_t    cmd,
   output logic                   crc_clear,
   output eth_rx_pkg::buf_wr_t    buf_wr,
   output eth_rx_pkg::rx_status_t status,
   output logic [31:0]            drops
);

   typedef enum logic [2:0] {
      st_idle,
      st_preamble,
      st_addr,
      st_data,
      st_settle,
      st_hold,
      st_discard
   } state_t;

   state_t                        state;
   logic [eth_rx_pkg::size_w-1:0] size;
   logic                          own_ok;
   logic                          bcast_ok;
   logic                          own_next;
   logic                          bcast_next;
   logic [7:0]                    mac_byte;
   logic                          room;
   logic                          active_q;
   logic                          drop_now;
   logic                          frame_ready;
   logic                          crc_err;
   logic                          dv_seen;

   assign room = 32'(size) < eth_rx_pkg::buf_words * 4;

   // Expected address byte, only meaningful for the first six bytes
   assign mac_byte = eth_rx_pkg::mac_addr[8 * (5 - int'(size[2:0])) +: 8];
   assign own_next = own_ok && (rx_byte.data == mac_byte);
   assign bcast_next = bcast_ok && (rx_byte.data == 8'hFF);

   assign crc_clear = (state == st_idle) || (state == st_preamble);

   always_comb begin
      buf_wr.addr = size[8:0];
      buf_wr.data = rx_byte.data;
      buf_wr.en = rx_byte.valid && ((state == st_addr) || (state == st_data && room));
   end

   always_comb begin
      drop_now = 1'b0;
      case (state)
         st_addr: drop_now = rx_byte.valid && (size[2:0] == 3'd5) && !own_next && !bcast_next;
         st_data: drop_now = rx_byte.valid && !room;
         // New frame while the buffer is still owned by software
         st_hold: drop_now = rx_byte.active && !active_q;
         default: drop_now = 1'b0;
      endcase
   end

   always_ff @(posedge RX_CLK or posedge rst) begin
      if (rst) begin
         state <= st_idle;
         size <= '0;
         own_ok <= 1'b0;
         bcast_ok <= 1'b0;
         active_q <= 1'b0;
         frame_ready <= 1'b0;
         crc_err <= 1'b0;
         dv_seen <= 1'b0;
         drops <= '0;
      end else begin
         active_q <= rx_byte.active;
         if (rx_byte.active) begin
            dv_seen <= 1'b1;
         end
         if (drop_now) begin
            drops <= drops + 32'd1;
         end
         // Soft reset returns the FSM to idle, the drop count survives
         if (cmd.soft_rst) begin
            state <= st_idle;
            size <= '0;
            frame_ready <= 1'b0;
            crc_err <= 1'b0;
         end else begin
            case (state)
               st_idle: begin
                  if (rx_byte.valid) begin
                     size <= '0;
                     own_ok <= 1'b1;
                     bcast_ok <= 1'b1;
                     if (rx_byte.data == 8'hD5) begin
                        state <= st_addr;
                     end else if (rx_byte.data == 8'h55) begin
                        state <= st_preamble;
                     end else begin
                        state <= st_discard;
                     end
                  end
               end
               st_preamble: begin
                  if (rx_byte.valid) begin
                     if (rx_byte.data == 8'hD5) begin
                        state <= st_addr;
                     end else if (rx_byte.data != 8'h55) begin
                        state <= st_discard;
                     end
                  end else if (!rx_byte.active) begin
                     state <= st_idle;
                  end
               end
               st_addr: begin
                  if (rx_byte.valid) begin
                     size <= size + 1'b1;
                     own_ok <= own_next;
                     bcast_ok <= bcast_next;
                     if (size[2:0] == 3'd5) begin
                        state <= (own_next || bcast_next) ? st_data : st_discard;
                     end
                  end else if (!rx_byte.active) begin
                     // Runt, ended inside the address
                     state <= st_idle;
                  end
               end
               st_data: begin
                  if (rx_byte.valid) begin
                     if (room) begin
                        size <= size + 1'b1;
                     end else begin
                        state <= st_discard;
                     end
                  end else if (!rx_byte.active) begin
                     frame_ready <= 1'b1;
                     crc_err <= !crc_good;
                     state <= st_settle;
                  end
               end
               // Lets the packer flush the last partial word
               st_settle: state <= st_hold;
               st_hold: begin
                  if (cmd.ack) begin
                     frame_ready <= 1'b0;
                     state <= rx_byte.active ? st_discard : st_idle;
                  end
               end
               st_discard: begin
                  if (!rx_byte.active) begin
                     state <= st_idle;
                  end
               end
               default: state <= st_idle;
            endcase
         end
      end
   end

   assign status = '{frame_ready: frame_ready, crc_err: crc_err, size: size, dv_seen: dv_seen};

endmodule

//--- hdl/eth_crc32.sv
`timescale 1ns/1ps

module eth_crc32 (
   input  logic                 RX_CLK,
   input  logic                 rst,
   input  logic                 clear,
   input  eth_rx_pkg::rx_byte_t rx_byte,
   output logic                 crc_good
);

   logic [31:0] crc_q;

   // One byte through the reflected LFSR, LSB first
   function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] d);
      logic [31:0] c;
      c = crc;
      for (int i = 0; i < 8; i++) begin
         if (c[0] ^ d[i]) begin
            c = (c >> 1) ^ eth_rx_pkg::crc_poly;
         end else begin
            c = c >> 1;
         end
      end
      return c;
   endfunction

   always_ff @(posedge RX_CLK or posedge rst) begin
      if (rst) begin
         crc_q <= '1;
      end else if (clear) begin
         crc_q <= '1;
      end else if (rx_byte.valid) begin
         crc_q <= crc_byte(crc_q, rx_byte.data);
      end
   end

   // Register holds the residue once the FCS has gone through
   assign crc_good = (crc_q == eth_rx_pkg::crc_residue);

endmodule

//--- hdl/mii_nibble_assembler.sv
`timescale 1ns/1ps

module mii_nibble_assembler (
   input  logic                 RX_CLK,
   input  logic                 rst,
   input  eth_rx_pkg::mii_rx_t  mii,
   output eth_rx_pkg::rx_byte_t rx_byte
);

   eth_rx_pkg::mii_rx_t mii_q;
   logic                phase;
   logic [3:0]          low_nib;

   always_ff @(posedge RX_CLK or posedge rst) begin
      if (rst) begin
         mii_q <= '0;
         phase <= 1'b0;
         rx_byte <= '0;
      end else begin
         mii_q <= mii;
         rx_byte.valid <= 1'b0;
         // Level copy of DV, drops with the first idle nibble
         rx_byte.active <= mii_q.dv;
         if (!mii_q.dv) begin
            // Idle line, the next frame starts on a low nibble
            phase <= 1'b0;
         end else if (!phase) begin
            phase <= 1'b1;
         end else begin
            phase <= 1'b0;
            rx_byte.valid <= 1'b1;
            rx_byte.data <= {mii_q.data, low_nib};
         end
      end
   end

   // Low nibble holding register
   always_ff @(posedge RX_CLK) begin
      if (mii_q.dv && !phase) begin
         low_nib <= mii_q.data;
      end
   end

endmodule

//--- hdl/eth_rx_pkg.sv
package eth_rx_pkg;

   // Station address, first byte on the wire is the most significant
   localparam logic [47:0] mac_addr = 48'h02_00_00_00_00_39;

   // 128 words of 32 bits, 512 bytes per frame
   localparam int buf_words = 128;
   localparam int size_w = 10;

   // Reflected CRC-32 polynomial and the good-frame residue
   localparam logic [31:0] crc_poly = 32'hEDB88320;
   localparam logic [31:0] crc_residue = 32'hDEBB20E3;

   // AXI4-Lite byte offsets
   localparam logic [11:0] reg_status = 12'h000;
   localparam logic [11:0] reg_control = 12'h004;
   localparam logic [11:0] reg_drops = 12'h008;
   localparam logic [11:0] reg_phy = 12'h00C;
   localparam logic [11:0] buf_base = 12'h100;

   typedef struct packed {
      logic       dv;
      logic [3:0] data;
   } mii_rx_t;

   // active follows DV, valid marks a completed byte
   typedef struct packed {
      logic       valid;
      logic       active;
      logic [7:0] data;
   } rx_byte_t;

   typedef struct packed {
      logic       en;
      logic [8:0] addr;
      logic [7:0] data;
   } buf_wr_t;

   typedef struct packed {
      logic              frame_ready;
      logic              crc_err;
      logic [size_w-1:0] size;
      logic              dv_seen;
   } rx_status_t;

   typedef struct packed {
      logic ack;
      logic soft_rst;
   } rx_cmd_t;

endpackage
